//--- vlog.f
source/lc3b_pkg.sv
source/lc3b_control.sv
source/lc3b_regfile.sv
source/lc3b_alu.sv
source/lc3b_branch_unit.sv
source/lc3b_writeback.sv
source/lc3b_core.sv
verification/lc3b_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= lc3b_tb
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= vlog.f

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --timescale 1ns/1ps -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verification/lc3b_tb.sv
// directed testbench for lc3b_core; needs a simulator with timing support, every wait is bounded
`timescale 1ns/1ps

module lc3b_tb import lc3b_pkg::*;
();

	localparam int TIMEOUT = 500;

	typedef struct packed
	{
		word_t    pc;
		logic     wr;
		reg_idx_t dr;
		word_t    data;
		nzp_t     nzp;
		logic     branch;
		logic     taken;
		word_t    target;
	} ret_t;

	logic     clk;
	logic     arst_n;
	logic     in_valid;
	word_t    in_instr;
	word_t    in_pc;
	logic     in_ready;
	logic     ret_valid;
	word_t    ret_pc;
	logic     ret_wr;
	reg_idx_t ret_dr;
	word_t    ret_data;
	nzp_t     ret_nzp;
	logic     ret_br_taken;
	word_t    ret_target;
	logic     ret_ready;

	// reference model state and pending traffic
	ret_t  exp_q [$];
	word_t instr_q [$];
	word_t pc_q [$];
	word_t model_regs [8];
	nzp_t  model_cc;
	word_t next_pc;
	int    seed;
	int    checks;
	int    errors;

	lc3b_core dut_i
	(
		.clk          (clk),
		.arst_n       (arst_n),
		.in_valid     (in_valid),
		.in_instr     (in_instr),
		.in_pc        (in_pc),
		.in_ready     (in_ready),
		.ret_valid    (ret_valid),
		.ret_pc       (ret_pc),
		.ret_wr       (ret_wr),
		.ret_dr       (ret_dr),
		.ret_data     (ret_data),
		.ret_nzp      (ret_nzp),
		.ret_br_taken (ret_br_taken),
		.ret_target   (ret_target),
		.ret_ready    (ret_ready)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#10 clk = ~clk;
	end

	function automatic word_t encode_op(input logic [3:0] op, input reg_idx_t dr,
		input reg_idx_t sr, input logic bit5, input logic [4:0] low);
		return {op, dr, sr, bit5, low};
	endfunction

	function automatic word_t encode_offset(input logic [3:0] op, input logic [2:0] field,
		input logic [8:0] off);
		return {op, field, off};
	endfunction

	function automatic nzp_t nzp_of(input word_t v);
		if (v[15])
			return 3'b100;
		else if (v != 16'd0)
			return 3'b001;
		return 3'b010;
	endfunction

	task automatic check_word(input string name, input string what, input word_t exp,
		input word_t act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("mismatch %s %s: expected %h actual %h", name, what, exp, act);
		end
	endtask

	task automatic check_idx(input string name, input string what, input reg_idx_t exp,
		input reg_idx_t act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("mismatch %s %s: expected %0d actual %0d", name, what, exp, act);
		end
	endtask

	task automatic check_nzp(input string name, input string what, input nzp_t exp,
		input nzp_t act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("mismatch %s %s: expected %b actual %b", name, what, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input string what, input logic exp,
		input logic act);
		checks++;
		if (exp !== act)
		begin
			errors++;
			$display("mismatch %s %s: expected %b actual %b", name, what, exp, act);
		end
	endtask

	// ISA-level model; queues the instruction and its expected retirement
	task automatic add_instr(input word_t instr);
		ret_t              r;
		word_t             a;
		word_t             b;
		logic signed [15:0] sa;
		logic [3:0]        amt;
		r = '0;
		a = model_regs[instr[8:6]];
		sa = a;
		b = instr[5] ? {{11{instr[4]}}, instr[4:0]} : model_regs[instr[2:0]];
		amt = instr[3:0];
		r.pc = next_pc;
		r.target = next_pc + 16'd2 + {{6{instr[8]}}, instr[8:0], 1'b0};
		r.wr = 1'b1;
		r.dr = instr[11:9];
		case (instr[15:12])
			4'b0001: r.data = a + b;
			4'b0101: r.data = a & b;
			4'b1001: r.data = ~a;
			4'b1101:
			begin
				if (!instr[4])
					r.data = a << amt;
				else if (!instr[5])
					r.data = a >> amt;
				else
					r.data = sa >>> amt;
			end
			4'b1110: r.data = r.target;
			default: r.wr = 1'b0;
		endcase
		// branch sees the code left by the previous instruction
		if (instr[15:12] == 4'b0000)
		begin
			r.branch = 1'b1;
			r.taken = |(instr[11:9] & model_cc);
		end
		if (r.wr)
		begin
			model_regs[r.dr] = r.data;
			model_cc = nzp_of(r.data);
		end
		r.nzp = model_cc;
		exp_q.push_back(r);
		instr_q.push_back(instr);
		pc_q.push_back(next_pc);
		next_pc = next_pc + 16'd2;
	endtask

	task automatic compare_retire(input string name);
		ret_t r;
		if (exp_q.size() == 0)
		begin
			errors++;
			$display("retirement seen in test %s with no instruction outstanding", name);
			return;
		end
		r = exp_q.pop_front();
		check_word(name, "pc", r.pc, ret_pc);
		check_flag(name, "wr", r.wr, ret_wr);
		if (r.wr)
		begin
			check_idx(name, "dr", r.dr, ret_dr);
			check_word(name, "data", r.data, ret_data);
		end
		check_nzp(name, "nzp", r.nzp, ret_nzp);
		check_flag(name, "br_taken", r.taken, ret_br_taken);
		if (r.branch)
			check_word(name, "target", r.target, ret_target);
	endtask

	task automatic apply_reset();
		in_valid = 1'b0;
		in_instr = '0;
		in_pc = '0;
		ret_ready = 1'b1;
		arst_n = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		for (int i = 0; i < 8; i++)
			model_regs[i] = '0;
		model_cc = CC_RESET;
		next_pc = 16'h3000;
		exp_q.delete();
		instr_q.delete();
		pc_q.delete();
	endtask

	// drive on the falling edge, sample 1 ns later while everything is settled
	task automatic run_stream(input string name, input logic random_ready);
		int          cycles;
		logic [31:0] rnd;
		cycles = 0;
		while ((exp_q.size() != 0) && (cycles < TIMEOUT))
		begin
			@(negedge clk);
			rnd = $random(seed);
			ret_ready = random_ready ? rnd[0] : 1'b1;
			in_valid = (instr_q.size() != 0);
			if (in_valid)
			begin
				in_instr = instr_q[0];
				in_pc = pc_q[0];
			end
			#1;
			if (ret_valid && !ret_ready && in_ready)
			begin
				errors++;
				$display("in_ready high while the retire port is stalled in test %s", name);
			end
			if (ret_valid && ret_ready)
				compare_retire(name);
			if (in_valid && in_ready)
			begin
				void'(instr_q.pop_front());
				void'(pc_q.pop_front());
			end
			cycles++;
		end
		if (exp_q.size() != 0)
		begin
			errors++;
			$display("timeout in test %s, %0d retirements never arrived", name, exp_q.size());
			exp_q.delete();
			instr_q.delete();
			pc_q.delete();
		end
		@(negedge clk);
		in_valid = 1'b0;
		ret_ready = 1'b1;
	endtask

	task automatic report_test(input string name, input int e0);
		$display("test %s finished with %0d errors", name, errors - e0);
	endtask

	task automatic test_reset_latency();
		int e0;
		e0 = errors;
		apply_reset();
		#1;
		check_flag("reset", "ret_valid", 1'b0, ret_valid);
		check_flag("reset", "in_ready", 1'b1, in_ready);
		add_instr(encode_op(OP_ADD, 3'd1, 3'd0, 1'b1, 5'd9));
		@(negedge clk);
		in_valid = 1'b1;
		in_instr = instr_q.pop_front();
		in_pc = pc_q.pop_front();
		#1;
		check_flag("latency", "in_ready before T", 1'b1, in_ready);
		// edge T takes the instruction
		@(negedge clk);
		in_valid = 1'b0;
		#1;
		check_flag("latency", "ret_valid after T", 1'b0, ret_valid);
		@(negedge clk);
		#1;
		check_flag("latency", "ret_valid after T+1", 1'b1, ret_valid);
		if (ret_valid)
			compare_retire("latency");
		exp_q.delete();
		@(negedge clk);
		#1;
		check_flag("latency", "ret_valid after drain", 1'b0, ret_valid);
		report_test("reset_latency", e0);
	endtask

	task automatic test_arith();
		int e0;
		e0 = errors;
		add_instr(encode_op(OP_AND, 3'd1, 3'd1, 1'b1, 5'd0));
		add_instr(encode_op(OP_ADD, 3'd1, 3'd1, 1'b1, 5'd5));
		add_instr(encode_op(OP_ADD, 3'd2, 3'd1, 1'b1, 5'h1d));
		add_instr(encode_op(OP_ADD, 3'd3, 3'd1, 1'b0, {2'b00, 3'd2}));
		add_instr(encode_op(OP_AND, 3'd4, 3'd3, 1'b0, {2'b00, 3'd1}));
		add_instr(encode_op(OP_NOT, 3'd5, 3'd3, 1'b1, 5'h1f));
		add_instr(encode_op(OP_AND, 3'd6, 3'd5, 1'b1, 5'h10));
		add_instr(encode_op(OP_AND, 3'd0, 3'd0, 1'b1, 5'd0));
		run_stream("arith", 1'b0);
		report_test("arith", e0);
	endtask

	task automatic test_shift();
		int e0;
		e0 = errors;
		// r1 = -8, then every shift mode on it
		add_instr(encode_op(OP_AND, 3'd1, 3'd1, 1'b1, 5'd0));
		add_instr(encode_op(OP_ADD, 3'd1, 3'd1, 1'b1, 5'h18));
		add_instr(encode_op(OP_SHF, 3'd2, 3'd1, 1'b0, {1'b0, 4'd3}));
		add_instr(encode_op(OP_SHF, 3'd3, 3'd1, 1'b0, {1'b1, 4'd4}));
		add_instr(encode_op(OP_SHF, 3'd4, 3'd1, 1'b1, {1'b1, 4'd2}));
		add_instr(encode_op(OP_SHF, 3'd5, 3'd1, 1'b1, {1'b1, 4'd15}));
		add_instr(encode_op(OP_SHF, 3'd6, 3'd1, 1'b0, {1'b0, 4'd15}));
		run_stream("shift", 1'b0);
		report_test("shift", e0);
	endtask

	task automatic test_forward();
		int e0;
		e0 = errors;
		add_instr(encode_op(OP_AND, 3'd7, 3'd7, 1'b1, 5'd0));
		for (int i = 0; i < 4; i++)
			add_instr(encode_op(OP_ADD, 3'd7, 3'd7, 1'b1, 5'd3));
		add_instr(encode_op(OP_ADD, 3'd7, 3'd7, 1'b0, {2'b00, 3'd7}));
		add_instr(encode_op(OP_ADD, 3'd6, 3'd7, 1'b1, 5'h1f));
		add_instr(encode_op(OP_ADD, 3'd7, 3'd7, 1'b0, {2'b00, 3'd6}));
		run_stream("forward", 1'b0);
		report_test("forward", e0);
	endtask

	task automatic test_branch();
		int e0;
		e0 = errors;
		add_instr(encode_offset(OP_LEA, 3'd2, 9'h1fb));
		add_instr(encode_offset(OP_LEA, 3'd3, 9'h040));
		for (int c = 0; c < 3; c++)
		begin
			// r0 zero, then negative, then positive
			case (c)
				0: add_instr(encode_op(OP_AND, 3'd0, 3'd0, 1'b1, 5'd0));
				1: add_instr(encode_op(OP_ADD, 3'd0, 3'd0, 1'b1, 5'h1f));
				default: add_instr(encode_op(OP_ADD, 3'd0, 3'd0, 1'b1, 5'd2));
			endcase
			for (int m = 0; m < 8; m++)
				add_instr(encode_offset(OP_BR, 3'(m), 9'(m * 37 - 100)));
		end
		run_stream("branch", 1'b0);
		report_test("branch", e0);
	endtask

	task automatic test_backpressure();
		int          e0;
		logic [31:0] rnd;
		logic [3:0]  op;
		e0 = errors;
		for (int i = 0; i < 40; i++)
		begin
			rnd = $random(seed);
			case (rnd[18:16])
				3'd0: op = OP_ADD;
				3'd1: op = OP_AND;
				3'd2: op = OP_NOT;
				3'd3: op = OP_SHF;
				3'd4: op = OP_LEA;
				3'd5: op = OP_BR;
				// a store opcode, which retires as a no-op
				3'd6: op = 4'b0011;
				default: op = OP_ADD;
			endcase
			add_instr({op, rnd[11:0]});
		end
		run_stream("backpressure", 1'b1);
		report_test("backpressure", e0);
	endtask

	initial
	begin
		seed = 32'h6a01bbd9;
		checks = 0;
		errors = 0;
		test_reset_latency();
		test_arith();
		test_shift();
		test_forward();
		test_branch();
		test_backpressure();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

//--- source/lc3b_core.sv
// two-stage LC-3b execute core; one instruction per cycle, retire one edge after the execute edge
`timescale 1ns/1ps

module lc3b_core import lc3b_pkg::*;
(
	input  logic     clk,
	input  logic     arst_n,
	input  logic     in_valid,
	input  word_t    in_instr,
	input  word_t    in_pc,
	output logic     in_ready,
	output logic     ret_valid,
	output word_t    ret_pc,
	output logic     ret_wr,
	output reg_idx_t ret_dr,
	output word_t    ret_data,
	output nzp_t     ret_nzp,
	output logic     ret_br_taken,
	output word_t    ret_target,
	input  logic     ret_ready
);

	reg_idx_t sr1;
	reg_idx_t sr2;
	logic     advance;
	logic     ex_fire;
	ctrl_t    ex_ctrl;
	word_t    opnd_a;
	word_t    opnd_b;
	word_t    alu_result;
	nzp_t     new_nzp;
	nzp_t     cc_q;
	word_t    target;
	logic     br_taken;
	logic     wr_en;
	reg_idx_t wr_dr;
	word_t    wr_data;

	lc3b_control control_i
	(
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.in_instr  (in_instr),
		.in_pc     (in_pc),
		.in_ready  (in_ready),
		.ret_valid (ret_valid),
		.ret_ready (ret_ready),
		.sr1       (sr1),
		.sr2       (sr2),
		.advance   (advance),
		.ex_fire   (ex_fire),
		.ex_ctrl   (ex_ctrl)
	);

	lc3b_regfile regfile_i
	(
		.clk     (clk),
		.arst_n  (arst_n),
		.advance (advance),
		.sr1     (sr1),
		.sr2     (sr2),
		.wr_en   (wr_en),
		.wr_dr   (wr_dr),
		.wr_data (wr_data),
		.opnd_a  (opnd_a),
		.opnd_b  (opnd_b)
	);

	lc3b_alu alu_i
	(
		.ex_ctrl    (ex_ctrl),
		.opnd_a     (opnd_a),
		.opnd_b     (opnd_b),
		.alu_result (alu_result)
	);

	lc3b_branch_unit branch_unit_i
	(
		.clk      (clk),
		.arst_n   (arst_n),
		.ex_ctrl  (ex_ctrl),
		.ex_fire  (ex_fire),
		.new_nzp  (new_nzp),
		.cc_q     (cc_q),
		.target   (target),
		.br_taken (br_taken)
	);

	lc3b_writeback writeback_i
	(
		.clk          (clk),
		.arst_n       (arst_n),
		.advance      (advance),
		.ex_fire      (ex_fire),
		.ex_ctrl      (ex_ctrl),
		.alu_result   (alu_result),
		.target       (target),
		.br_taken     (br_taken),
		.cc_q         (cc_q),
		.ret_ready    (ret_ready),
		.new_nzp      (new_nzp),
		.wr_en        (wr_en),
		.wr_dr        (wr_dr),
		.wr_data      (wr_data),
		.ret_valid    (ret_valid),
		.ret_wr       (ret_wr),
		.ret_pc       (ret_pc),
		.ret_data     (ret_data),
		.ret_target   (ret_target),
		.ret_dr       (ret_dr),
		.ret_nzp      (ret_nzp),
		.ret_br_taken (ret_br_taken)
	);

endmodule

//--- source/lc3b_writeback.sv
// result select, register write and retire register; ret_nzp holds the code after the instruction
`timescale 1ns/1ps

module lc3b_writeback import lc3b_pkg::*;
(
	input  logic     clk,
	input  logic     arst_n,
	input  logic     advance,
	input  logic     ex_fire,
	input  ctrl_t    ex_ctrl,
	input  word_t    alu_result,
	input  word_t    target,
	input  logic     br_taken,
	input  nzp_t     cc_q,
	input  logic     ret_ready,
	output nzp_t     new_nzp,
	output logic     wr_en,
	output reg_idx_t wr_dr,
	output word_t    wr_data,
	output logic     ret_valid,
	output logic     ret_wr,
	output word_t    ret_pc,
	output word_t    ret_data,
	output word_t    ret_target,
	output reg_idx_t ret_dr,
	output nzp_t     ret_nzp,
	output logic     ret_br_taken
);

	word_t result;

	// LEA writes its address, everything else the ALU output
	assign result = ex_ctrl.lea ? target : alu_result;

	always_comb
	begin
		if (result[15])
			new_nzp = 3'b100;
		else if (|result)
			new_nzp = 3'b001;
		else
			new_nzp = 3'b010;
	end

	assign wr_en   = ex_fire && ex_ctrl.reg_wr;
	assign wr_dr   = ex_ctrl.dr;
	assign wr_data = result;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			ret_valid    <= 1'b0;
			ret_wr       <= 1'b0;
			ret_pc       <= '0;
			ret_data     <= '0;
			ret_target   <= '0;
			ret_dr       <= '0;
			ret_nzp      <= CC_RESET;
			ret_br_taken <= 1'b0;
		end
		else
		begin
			// slot fills on a fired instruction and drains once accepted
			if (ex_fire)
				ret_valid <= 1'b1;
			else if (ret_ready)
				ret_valid <= 1'b0;
			if (advance)
			begin
				ret_wr       <= ex_ctrl.reg_wr;
				ret_pc       <= ex_ctrl.pc;
				ret_data     <= result;
				ret_target   <= target;
				ret_dr       <= ex_ctrl.dr;
				ret_nzp      <= (ex_fire && ex_ctrl.set_cc) ? new_nzp : cc_q;
				ret_br_taken <= br_taken;
			end
		end
	end

endmodule

//--- source/lc3b_branch_unit.sv
// condition-code register and branch resolve; the branch compares against cc before this instruction
`timescale 1ns/1ps

module lc3b_branch_unit import lc3b_pkg::*;
(
	input  logic  clk,
	input  logic  arst_n,
	input  ctrl_t ex_ctrl,
	input  logic  ex_fire,
	input  nzp_t  new_nzp,
	output nzp_t  cc_q,
	output word_t target,
	output logic  br_taken
);

	// PC-relative target with the offset already scaled to bytes
	assign target = ex_ctrl.pc + 16'd2 + ex_ctrl.offset;

	// taken when any mask bit matches the current code
	assign br_taken = ex_ctrl.branch && (|(ex_ctrl.br_mask & cc_q));

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			cc_q <= CC_RESET;
		end
		else if (ex_fire && ex_ctrl.set_cc)
		begin
			cc_q <= new_nzp;
		end
	end

endmodule

//--- source/lc3b_alu.sv
// combinational ALU; shift amount comes from the low four bits of the immediate field
`timescale 1ns/1ps

module lc3b_alu import lc3b_pkg::*;
(
	input  ctrl_t ex_ctrl,
	input  word_t opnd_a,
	input  word_t opnd_b,
	output word_t alu_result
);

	word_t      opnd_b_sel;
	logic [3:0] shamt;

	assign opnd_b_sel = ex_ctrl.use_imm ? ex_ctrl.imm : opnd_b;
	assign shamt      = ex_ctrl.imm[3:0];

	always_comb
	begin
		case (ex_ctrl.alu_op)
			ALU_ADD:
				alu_result = opnd_a + opnd_b_sel;
			ALU_AND:
				alu_result = opnd_a & opnd_b_sel;
			ALU_NOT:
				alu_result = ~opnd_a;
			ALU_SLL:
				alu_result = opnd_a << shamt;
			ALU_SRL:
				alu_result = opnd_a >> shamt;
			// arithmetic right keeps the sign bit
			ALU_SRA:
				alu_result = word_t'($signed(opnd_a) >>> shamt);
			default:
				alu_result = opnd_a;
		endcase
	end

endmodule

//--- source/lc3b_regfile.sv
// eight registers with reads registered on advance; the only bypass is from the write port
`timescale 1ns/1ps

module lc3b_regfile import lc3b_pkg::*;
(
	input  logic     clk,
	input  logic     arst_n,
	input  logic     advance,
	input  reg_idx_t sr1,
	input  reg_idx_t sr2,
	input  logic     wr_en,
	input  reg_idx_t wr_dr,
	input  word_t    wr_data,
	output word_t    opnd_a,
	output word_t    opnd_b
);

	word_t regs [8];

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
			opnd_a <= '0;
			opnd_b <= '0;
		end
		else
		begin
			if (wr_en)
				regs[wr_dr] <= wr_data;
			// the write lands on the same edge as the next read, so forward it
			if (advance)
			begin
				opnd_a <= (wr_en && wr_dr == sr1) ? wr_data : regs[sr1];
				opnd_b <= (wr_en && wr_dr == sr2) ? wr_data : regs[sr2];
			end
		end
	end

endmodule

//--- source/lc3b_control.sv
// decoder and execute-stage register; in_pc is taken as given, there is no fetch or flush
`timescale 1ns/1ps

module lc3b_control import lc3b_pkg::*;
(
	input  logic     clk,
	input  logic     arst_n,
	input  logic     in_valid,
	input  word_t    in_instr,
	input  word_t    in_pc,
	output logic     in_ready,
	input  logic     ret_valid,
	input  logic     ret_ready,
	output reg_idx_t sr1,
	output reg_idx_t sr2,
	output logic     advance,
	output logic     ex_fire,
	output ctrl_t    ex_ctrl
);

	opcode_t opcode;
	ctrl_t   dec_ctrl;
	logic    ex_valid;

	assign opcode = opcode_t'(in_instr[15:12]);

	// register read indices follow the LC-3b field positions
	assign sr1 = in_instr[8:6];
	assign sr2 = in_instr[2:0];

	// everything moves unless the retire slot is full and stalled
	assign advance  = !ret_valid || ret_ready;
	assign in_ready = advance;
	assign ex_fire  = ex_valid && advance;

	always_comb
	begin
		dec_ctrl         = '0;
		dec_ctrl.alu_op  = ALU_PASS;
		dec_ctrl.dr      = in_instr[11:9];
		dec_ctrl.pc      = in_pc;
		dec_ctrl.imm     = {{11{in_instr[4]}}, in_instr[4:0]};
		dec_ctrl.offset  = {{6{in_instr[8]}}, in_instr[8:0], 1'b0};
		case (opcode)
			OP_ADD, OP_AND:
			begin
				dec_ctrl.alu_op  = (opcode == OP_ADD) ? ALU_ADD : ALU_AND;
				// bit 5 picks imm5 over SR2
				dec_ctrl.use_imm = in_instr[5];
				dec_ctrl.reg_wr  = 1'b1;
				dec_ctrl.set_cc  = 1'b1;
			end
			OP_NOT:
			begin
				dec_ctrl.alu_op = ALU_NOT;
				dec_ctrl.reg_wr = 1'b1;
				dec_ctrl.set_cc = 1'b1;
			end
			OP_SHF:
			begin
				// bit 4 is the direction, bit 5 the arithmetic flag
				if (!in_instr[4])
					dec_ctrl.alu_op = ALU_SLL;
				else if (!in_instr[5])
					dec_ctrl.alu_op = ALU_SRL;
				else
					dec_ctrl.alu_op = ALU_SRA;
				dec_ctrl.imm     = {12'b0, in_instr[3:0]};
				dec_ctrl.use_imm = 1'b1;
				dec_ctrl.reg_wr  = 1'b1;
				dec_ctrl.set_cc  = 1'b1;
			end
			OP_BR:
			begin
				dec_ctrl.branch  = 1'b1;
				dec_ctrl.br_mask = in_instr[11:9];
			end
			OP_LEA:
			begin
				// LEA updates the condition code here as well
				dec_ctrl.lea    = 1'b1;
				dec_ctrl.reg_wr = 1'b1;
				dec_ctrl.set_cc = 1'b1;
			end
			default:
			begin
				// unknown opcode retires as a no-op
				dec_ctrl.dr = '0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			ex_valid <= 1'b0;
			ex_ctrl  <= '0;
		end
		else if (advance)
		begin
			ex_valid <= in_valid;
			ex_ctrl  <= dec_ctrl;
		end
	end

endmodule

//--- source/lc3b_pkg.sv
// shared LC-3b types; only BR, ADD, AND, NOT, SHF and LEA are decoded, other opcodes retire as no-ops
package lc3b_pkg;

	typedef logic [15:0] word_t;
	typedef logic [2:0]  reg_idx_t;

	// bit 2 negative, bit 1 zero, bit 0 positive
	typedef logic [2:0]  nzp_t;

	typedef enum logic [3:0]
	{
		OP_BR  = 4'b0000,
		OP_ADD = 4'b0001,
		OP_AND = 4'b0101,
		OP_NOT = 4'b1001,
		OP_SHF = 4'b1101,
		OP_LEA = 4'b1110
	} opcode_t;

	typedef enum logic [2:0]
	{
		ALU_ADD,
		ALU_AND,
		ALU_NOT,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_PASS
	} alu_op_t;

	// execute-stage control word
	typedef struct packed
	{
		alu_op_t  alu_op;
		reg_idx_t dr;
		logic     use_imm;
		// sign-extended imm5, or the shift amount in the low four bits
		word_t    imm;
		word_t    pc;
		// sign-extended offset9 already shifted left by one
		word_t    offset;
		logic     reg_wr;
		logic     set_cc;
		logic     branch;
		nzp_t     br_mask;
		logic     lea;
	} ctrl_t;

	localparam nzp_t CC_RESET = 3'b010;

endpackage
